// ==== common/mboxTypesPkg.sv ====
package mboxTypesPkg;

  // Physical page, word within a quad, and per-word request mask
  typedef logic [6:0] pageAdrT;
  typedef logic [1:0] wordAdrT;
  typedef logic [3:0] rqMaskT;

  // Request as presented by the cache side
  typedef struct packed {
    pageAdrT page;
    wordAdrT word;
    rqMaskT  mask;
    logic    read;
    logic    write;
  } cacheRqT;

  // Request as driven to memory
  typedef struct packed {
    logic    startA;
    logic    startB;
    pageAdrT page;
    wordAdrT word;
    rqMaskT  mask;
    logic    read;
    logic    write;
    // Odd parity over page, word, mask and flags
    logic    adrPar;
  } memRqT;

endpackage

// ==== common/mboxCtlPkg.sv ====
package mboxCtlPkg;

  // Words in a quad
  localparam int rqWidth = 4;

  // Cycles from memory data-valid to core data-valid
  localparam int dataValDelay = 2;

  typedef logic [2:0] diagSelT;
  typedef logic [7:0] diagWordT;

  // Diagnostic read codes, the rest read zero
  localparam diagSelT diagStatus = 3'd0;
  localparam diagSelT diagAdr    = 3'd1;
  localparam diagSelT diagRq     = 3'd2;

  typedef struct packed {
    logic               phaseA;
    // Bit 1 is start A, bit 0 is start B
    logic [1:0]         memStart;
    logic               busy;
    logic               lastAcknSeen;
    logic [rqWidth-1:0] mask;
    logic               coreDataValid;
  } startStatusT;

endpackage

// ==== memStart/memStartCtl.sv ====
`timescale 1ns/1ps
module memStartCtl (
  input  logic                    clk,
  input  logic                    arstN,
  input  mboxTypesPkg::cacheRqT   cacheRq,
  input  logic                    rqValid,
  input  logic                    memAckn,
  input  logic                    memDataValid,
  output mboxCtlPkg::startStatusT startStatus
);
  import mboxCtlPkg::*;

  logic                    phaseA;
  logic                    startA;
  logic                    startB;
  logic                    busy;
  logic                    accept;
  logic                    acknTaken;
  logic                    lastAckn;
  logic                    lastAcknSeen;
  logic                    startClr;
  logic [rqWidth-1:0]      maskHold;
  logic [rqWidth-1:0]      rqLeft;
  logic [rqWidth-1:0]      rqLeftNext;
  logic [dataValDelay-1:0] dvPipe;

  assign busy   = startA | startB;
  assign accept = rqValid & ~busy;

  // Each acknowledge retires the lowest word still pending
  assign rqLeftNext = rqLeft & (rqLeft - 1'b1);
  assign acknTaken  = memAckn & busy & ~lastAcknSeen & (rqLeft != '0);
  assign lastAckn   = acknTaken & (rqLeftNext == '0);

  // Start drops one edge after the last word is acknowledged
  assign startClr = busy & lastAcknSeen;

  // Free-running A/B phase, A first out of reset
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      phaseA <= 1'b1;
    end else begin
      phaseA <= ~phaseA;
    end
  end

  // Start lands on whichever phase is coming
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      startA <= 1'b0;
      startB <= 1'b0;
    end else if (accept) begin
      startA <= ~phaseA;
      startB <= phaseA;
    end else if (startClr) begin
      startA <= 1'b0;
      startB <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      maskHold <= '0;
      rqLeft   <= '0;
    end else if (accept) begin
      maskHold <= cacheRq.mask;
      rqLeft   <= cacheRq.mask;
    end else if (acknTaken) begin
      rqLeft <= rqLeftNext;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      lastAcknSeen <= 1'b0;
    end else if (startClr) begin
      lastAcknSeen <= 1'b0;
    end else if (lastAckn) begin
      lastAcknSeen <= 1'b1;
    end
  end

  // Data-valid delay line, pulses may overlap
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      dvPipe <= '0;
    end else begin
      dvPipe <= {dvPipe[dataValDelay-2:0], memDataValid};
    end
  end

  always_comb begin
    startStatus.phaseA        = phaseA;
    startStatus.memStart      = {startA, startB};
    startStatus.busy          = busy;
    startStatus.lastAcknSeen  = lastAcknSeen;
    startStatus.mask          = maskHold;
    startStatus.coreDataValid = dvPipe[dataValDelay-1];
  end

endmodule

// ==== source/cacheAdrPath.sv ====
`timescale 1ns/1ps
module cacheAdrPath (
  input  logic                  clk,
  input  logic                  arstN,
  input  mboxTypesPkg::cacheRqT cacheRq,
  input  logic                  rqValid,
  input  logic                  busy,
  input  logic                  refillHold,
  input  logic                  refillAdrEn,
  output mboxTypesPkg::pageAdrT pageHold,
  output mboxTypesPkg::wordAdrT wordHold,
  output mboxTypesPkg::pageAdrT cacheAdr,
  output logic                  writeOk
);
  import mboxTypesPkg::*;

  logic    accept;
  pageAdrT refillPage;
  logic    pageDiffers;

  assign accept = rqValid & ~busy;

  // Request address hold for the memory side
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pageHold <= '0;
      wordHold <= '0;
    end else if (accept) begin
      pageHold <= cacheRq.page;
      wordHold <= cacheRq.word;
    end
  end

  // Page held across a refill
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      refillPage <= '0;
    end else if (refillHold) begin
      refillPage <= cacheRq.page;
    end
  end

  // Refill cycles address the cache with the held page
  assign cacheAdr = refillAdrEn ? refillPage : cacheRq.page;

  // A write to the page being refilled must wait
  assign pageDiffers = (cacheRq.page != refillPage);
  assign writeOk     = ~refillHold | pageDiffers;

endmodule

// ==== source/mboxCombiner.sv ====
`timescale 1ns/1ps
module mboxCombiner (
  input  logic                    clk,
  input  logic                    arstN,
  input  mboxCtlPkg::startStatusT startStatus,
  input  mboxTypesPkg::pageAdrT   pageHold,
  input  mboxTypesPkg::wordAdrT   wordHold,
  input  mboxTypesPkg::cacheRqT   cacheRq,
  input  logic                    rqValid,
  input  logic                    forceBadPar,
  input  mboxCtlPkg::diagSelT     diagSel,
  output mboxTypesPkg::memRqT     memRq,
  output mboxCtlPkg::diagWordT    diagWord
);
  import mboxCtlPkg::*;

  logic accept;
  logic forceHold;
  logic rdHold;
  logic wrHold;
  logic adrPar;

  assign accept = rqValid & ~startStatus.busy;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      forceHold <= 1'b0;
      rdHold    <= 1'b0;
      wrHold    <= 1'b0;
    end else if (accept) begin
      forceHold <= forceBadPar;
      rdHold    <= cacheRq.read;
      wrHold    <= cacheRq.write;
    end
  end

  // Odd parity, flipped for the bad-parity diagnostic
  assign adrPar = ~(^{pageHold, wordHold, startStatus.mask, rdHold, wrHold}) ^ forceHold;

  always_comb begin
    memRq.startA = startStatus.memStart[1];
    memRq.startB = startStatus.memStart[0];
    memRq.page   = pageHold;
    memRq.word   = wordHold;
    memRq.mask   = startStatus.mask;
    memRq.read   = rdHold;
    memRq.write  = wrHold;
    memRq.adrPar = adrPar;
  end

  always_comb begin
    case (diagSel)
      diagStatus: diagWord = {startStatus.phaseA, startStatus.memStart, startStatus.busy,
                              startStatus.lastAcknSeen, startStatus.coreDataValid,
                              forceHold, adrPar};
      diagAdr:    diagWord = {1'b0, pageHold};
      diagRq:     diagWord = {startStatus.mask, wordHold, rdHold, wrHold};
      default:    diagWord = '0;
    endcase
  end

endmodule

// ==== source/mboxCtl.sv ====
`timescale 1ns/1ps
module mboxCtl (
  input  logic                   clk,
  input  logic                   arstN,
  input  mboxTypesPkg::cacheRqT  cacheRq,
  input  logic                   rqValid,
  input  logic                   forceBadPar,
  input  logic                   refillHold,
  input  logic                   refillAdrEn,
  input  logic                   memAckn,
  input  logic                   memDataValid,
  input  mboxCtlPkg::diagSelT    diagSel,
  output logic                   busy,
  output mboxTypesPkg::memRqT    memRq,
  output mboxTypesPkg::pageAdrT  cacheAdr,
  output logic                   writeOk,
  output logic                   coreDataValid,
  output mboxCtlPkg::diagWordT   diagWord
);
  import mboxTypesPkg::*;
  import mboxCtlPkg::*;

  startStatusT startStatus;
  pageAdrT     pageHold;
  wordAdrT     wordHold;

  memStartCtl uMemStart (
    .clk          (clk),
    .arstN        (arstN),
    .cacheRq      (cacheRq),
    .rqValid      (rqValid),
    .memAckn      (memAckn),
    .memDataValid (memDataValid),
    .startStatus  (startStatus)
  );

  cacheAdrPath uAdrPath (
    .clk         (clk),
    .arstN       (arstN),
    .cacheRq     (cacheRq),
    .rqValid     (rqValid),
    .busy        (startStatus.busy),
    .refillHold  (refillHold),
    .refillAdrEn (refillAdrEn),
    .pageHold    (pageHold),
    .wordHold    (wordHold),
    .cacheAdr    (cacheAdr),
    .writeOk     (writeOk)
  );

  mboxCombiner uCombiner (
    .clk         (clk),
    .arstN       (arstN),
    .startStatus (startStatus),
    .pageHold    (pageHold),
    .wordHold    (wordHold),
    .cacheRq     (cacheRq),
    .rqValid     (rqValid),
    .forceBadPar (forceBadPar),
    .diagSel     (diagSel),
    .memRq       (memRq),
    .diagWord    (diagWord)
  );

  assign busy          = startStatus.busy;
  assign coreDataValid = startStatus.coreDataValid;

endmodule

// ==== tests/mboxCtl_assertions.sv ====
`timescale 1ns/1ps
module mboxCtlAssertions (
  input logic                    clk,
  input logic                    arstN,
  input logic                    phaseA,
  input logic                    startA,
  input logic                    startB,
  input logic                    busy,
  input logic                    lastAcknSeen,
  input logic                    memDataValid,
  input mboxCtlPkg::startStatusT startStatus
);
  import mboxCtlPkg::*;

  // Start lands alone on the phase now current
  startExclusive: assert property (@(posedge clk) disable iff (!arstN)
    $rose(busy) |-> (startA == phaseA) && (startB == !phaseA))
    else $error("start is not set alone on the current phase");

  // Busy may only drop once the last word was acknowledged
  busyFallAfterAckn: assert property (@(posedge clk) disable iff (!arstN)
    $fell(busy) |-> $past(lastAcknSeen))
    else $error("busy fell without a final acknowledge");

  dataValidDelay: assert property (@(posedge clk) disable iff (!arstN)
    startStatus.coreDataValid == $past(memDataValid, dataValDelay))
    else $error("coreDataValid does not follow memDataValid by two cycles");

endmodule

// ==== tests/mboxCtlTb.sv ====
`timescale 1ns/1ps
module mboxCtlTb;
  import mboxTypesPkg::*;
  import mboxCtlPkg::*;

  localparam int stimCols = 12;
  localparam int maxLines = 32;

  logic       clk;
  logic       arstN;
  cacheRqT    cacheRq;
  logic       rqValid;
  logic       forceBadPar;
  logic       refillHold;
  logic       refillAdrEn;
  logic       memAckn;
  logic       memDataValid;
  diagSelT    diagSel;
  logic       busy;
  memRqT      memRq;
  pageAdrT    cacheAdr;
  logic       writeOk;
  logic       coreDataValid;
  diagWordT   diagWord;
  logic [7:0] stimMem [0:stimCols*maxLines-1];
  logic [1:0] dvHist = '0;
  memRqT      lastRq;
  int         edgeCount = 0;
  int         cycleLimit = 0;
  int         lineCount = 0;
  int         errorCount = 0;
  integer     seed = 32'h9abb_5857;

  mboxCtl u_dut (.*);

  bind memStartCtl mboxCtlAssertions uAssertions (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Cycle count since reset, memDataValid history, run limit
  always @(posedge clk) begin
    if (arstN)
      edgeCount <= edgeCount + 1;
    dvHist <= {dvHist[0], memDataValid};
    if (cycleLimit > 0 && edgeCount >= cycleLimit)
      stopOnFailure("Timeout: the run took more cycles than the stimulus allows");
  end

  always @(negedge clk) begin
    checkBit("coreDataValid", coreDataValid, dvHist[1]);
  end

  task automatic stopOnFailure(input string what);
    errorCount++;
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic checkBit(input string name, input logic got, input logic want);
    if (got !== want)
      stopOnFailure($sformatf("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, want));
  endtask

  task automatic checkMemRq(input string name, input memRqT got, input memRqT want);
    if (got !== want)
      stopOnFailure($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, want));
  endtask

  task automatic checkAdr(input string name, input pageAdrT got, input pageAdrT want);
    if (got !== want)
      stopOnFailure($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, want));
  endtask

  task automatic checkDiag(input string name, input diagWordT got, input diagWordT want);
    if (got !== want)
      stopOnFailure($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, want));
  endtask

  function automatic memRqT expectedMemRq(input cacheRqT rq, input logic badPar,
                                          input logic phase);
    memRqT m;
    int    ones;
    ones = 0;
    for (int b = 0; b < $bits(cacheRqT); b++)
      ones += int'(rq[b]);
    m.startA = phase;
    m.startB = ~phase;
    m.page   = rq.page;
    m.word   = rq.word;
    m.mask   = rq.mask;
    m.read   = rq.read;
    m.write  = rq.write;
    // Parity bit brings the count of ones to odd
    m.adrPar = ~ones[0] ^ badPar;
    return m;
  endfunction

  function automatic diagWordT expectedDiag(input diagSelT sel, input memRqT m,
                                            input logic phase, input logic badPar,
                                            input logic cdv);
    case (sel)
      diagStatus: return {phase, m.startA, m.startB, 1'b1, 1'b0, cdv, badPar, m.adrPar};
      diagAdr:    return {1'b0, m.page};
      diagRq:     return {m.mask, m.word, m.read, m.write};
      default:    return '0;
    endcase
  endfunction

  task automatic runLine(input int idx);
    int      base;
    int      acks;
    cacheRqT rq;
    memRqT   want;
    logic    phase;
    pageAdrT curPage;
    base        = idx * stimCols;
    rq.page     = stimMem[base][6:0];
    rq.word     = stimMem[base+1][1:0];
    rq.mask     = stimMem[base+2][3:0];
    rq.read     = stimMem[base+3][0];
    rq.write    = stimMem[base+4][0];
    cacheRq     = rq;
    forceBadPar = stimMem[base+5][0];
    diagSel     = stimMem[base+10][2:0];
    rqValid     = 1'b1;
    // Held request must not disturb the one still running
    while (busy) begin
      checkMemRq("memRq", memRq, lastRq);
      @(negedge clk);
    end
    @(negedge clk);
    rqValid = 1'b0;
    phase   = (edgeCount % 2) == 0;
    want    = expectedMemRq(rq, forceBadPar, phase);
    lastRq  = want;
    checkBit("busy", busy, 1'b1);
    checkMemRq("memRq", memRq, want);
    checkDiag("diagWord", diagWord, expectedDiag(diagSel, want, phase, forceBadPar, dvHist[1]));
    // Load refill page, then offer the same or another page
    refillHold = 1'b1;
    @(negedge clk);
    curPage      = stimMem[base+8][0] ? rq.page ^ 7'h2a : rq.page;
    cacheRq.page = curPage;
    refillHold   = stimMem[base+6][0];
    refillAdrEn  = stimMem[base+7][0];
    #10;
    checkBit("writeOk", writeOk, stimMem[base+11][0]);
    checkAdr("cacheAdr", cacheAdr, refillAdrEn ? rq.page : curPage);
    @(negedge clk);
    cacheRq.page = rq.page;
    refillHold   = 1'b0;
    refillAdrEn  = 1'b0;
    acks = 0;
    for (int b = 0; b < rqWidth; b++)
      acks += int'(rq.mask[b]);
    for (int k = 0; k < acks; k++) begin
      repeat ({$random(seed)} % (stimMem[base+9] + 1)) @(negedge clk);
      memAckn      = 1'b1;
      memDataValid = 1'b1;
      @(negedge clk);
      memAckn      = 1'b0;
      memDataValid = 1'b0;
      // Busy drops only on the edge after the last acknowledge
      checkBit("busy", busy, 1'b1);
      checkMemRq("memRq", memRq, want);
    end
  endtask

  initial begin
    arstN        = 1'b0;
    cacheRq      = '0;
    rqValid      = 1'b0;
    forceBadPar  = 1'b0;
    refillHold   = 1'b0;
    refillAdrEn  = 1'b0;
    memAckn      = 1'b0;
    memDataValid = 1'b0;
    diagSel      = '0;
    for (int i = 0; i < stimCols * maxLines; i++)
      stimMem[i] = 8'hff;
    $readmemh("tests/mboxCtl_stim.txt", stimMem);
    while (lineCount < maxLines && stimMem[lineCount*stimCols] != 8'hff)
      lineCount++;
    if (lineCount == 0)
      stopOnFailure("No stimulus lines were read from the stimulus file");
    cycleLimit = 60 * lineCount;
    repeat (8) @(negedge clk);
    arstN = 1'b1;
    @(negedge clk);
    checkBit("busy", busy, 1'b0);
    checkBit("memRq.startA", memRq.startA, 1'b0);
    checkBit("memRq.startB", memRq.startB, 1'b0);
    for (int i = 0; i < lineCount; i++)
      runLine(i);
    while (busy)
      @(negedge clk);
    repeat (3) @(negedge clk);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== tests/mboxCtl_stim.txt ====
// page word mask read write forceBadPar refillHold refillAdrEn altPage maxGap diagSel writeOk
// A line whose page is ff ends the list
12 1 f 1 0 0 1 1 0 0 0 0
45 2 3 1 0 1 1 0 1 2 1 1
7f 3 8 0 1 0 0 1 0 3 2 1
00 0 5 1 0 1 1 1 1 1 3 1
2a 1 1 0 1 0 1 0 0 0 4 0
55 2 e 1 0 0 0 0 1 2 0 1
3c 0 6 0 1 1 1 1 0 3 1 0
61 3 9 1 0 0 1 0 1 0 2 1
0f 2 7 1 1 0 0 1 0 1 5 1
70 1 2 0 1 1 1 1 1 2 6 1
19 0 b 1 0 0 1 0 0 1 7 0
66 3 4 0 1 1 0 0 0 0 0 1
ff

// ==== mboxCtl.f ====
common/mboxTypesPkg.sv
common/mboxCtlPkg.sv
memStart/memStartCtl.sv
source/cacheAdrPath.sv
source/mboxCombiner.sv
source/mboxCtl.sv
tests/mboxCtl_assertions.sv
tests/mboxCtlTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module mboxCtlTb -f mboxCtl.f -o mboxCtlSim &&
./obj_dir/mboxCtlSim | tee /dev/stderr | grep -q "Done: no errors" &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
